//--- hw/cache_pkg.sv
package cache_pkg;

  // Bank geometry
  localparam int LINE_BYTES = 16;
  localparam int NUM_SETS   = 4;
  localparam int NUM_WAYS   = 4;
  localparam int NUM_LINES  = NUM_SETS * NUM_WAYS;

  // Physical address split, tag | index | offset
  localparam int PADDR_W  = 15;
  localparam int OFFSET_W = 4;
  localparam int INDEX_W  = 2;
  localparam int TAG_W    = PADDR_W - INDEX_W - OFFSET_W;

  localparam int REQ_ID_W = 7;
  localparam int WAY_W    = 2;
  localparam int AGE_W    = 2;

  // Age of the line to be replaced next
  localparam int AGE_OLDEST = NUM_WAYS - 1;

  typedef logic [LINE_BYTES*8-1:0] line_t;
  typedef logic [LINE_BYTES-1:0]   byte_mask_t;
  typedef logic [PADDR_W-1:0]      paddr_t;
  typedef logic [TAG_W-1:0]        tag_t;
  typedef logic [INDEX_W-1:0]      index_t;
  typedef logic [WAY_W-1:0]        way_t;
  typedef logic [REQ_ID_W-1:0]     req_id_t;

  // 0 is most recently used, 3 is least
  typedef logic [AGE_W-1:0]        age_t;

  function automatic tag_t addr_tag(paddr_t addr);
    return addr[PADDR_W-1 -: TAG_W];
  endfunction

  function automatic index_t addr_index(paddr_t addr);
    return addr[OFFSET_W +: INDEX_W];
  endfunction

  // Line address with the offset cleared
  function automatic paddr_t line_addr(tag_t tag, index_t index);
    return {tag, index, {OFFSET_W{1'b0}}};
  endfunction

endpackage

//--- hw/cache_lookup_if.sv
`timescale 1ns/1ps

interface cache_lookup_if;
  import cache_pkg::*;

  // Lookup key from the controller
  index_t index;
  tag_t   tag;

  // Tag/state write, also makes the way newest
  logic   upd_en;
  way_t   upd_way;
  tag_t   upd_tag;
  logic   upd_valid;
  logic   upd_dirty;

  // LRU touch only
  logic   touch_en;
  way_t   touch_way;

  // Combinational lookup results
  logic   hit;
  way_t   hit_way;
  way_t   victim_way;
  logic   victim_valid;
  logic   victim_dirty;
  tag_t   victim_tag;

  modport ctrl (
    output index, tag,
    output upd_en, upd_way, upd_tag, upd_valid, upd_dirty,
    output touch_en, touch_way,
    input  hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag
  );

  modport array (
    input  index, tag,
    input  upd_en, upd_way, upd_tag, upd_valid, upd_dirty,
    input  touch_en, touch_way,
    output hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag
  );

endinterface

//--- hw/cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array (
  input logic          clk,
  input logic          rst_n,
  cache_lookup_if.array lookup
);
  import cache_pkg::*;

  tag_t tag_q   [NUM_SETS][NUM_WAYS];
  logic valid_q [NUM_SETS][NUM_WAYS];
  logic dirty_q [NUM_SETS][NUM_WAYS];
  age_t age_q   [NUM_SETS][NUM_WAYS];

  logic [NUM_WAYS-1:0] match;
  logic                inv_found;
  way_t                inv_way;
  way_t                old_way;
  logic                touch_any;
  way_t                touch_sel;
  age_t                touch_age;

  // Tag compare across the selected set
  always_comb begin
    lookup.hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = valid_q[lookup.index][w] && (tag_q[lookup.index][w] == lookup.tag);
      if (match[w]) begin
        lookup.hit_way = way_t'(w);
      end
    end
    lookup.hit = |match;
  end

  // Victim is the lowest invalid way, else the oldest one
  always_comb begin
    inv_found = 1'b0;
    inv_way   = '0;
    old_way   = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[lookup.index][w]) begin
        inv_found = 1'b1;
        inv_way   = way_t'(w);
      end
      if (age_q[lookup.index][w] == age_t'(AGE_OLDEST)) begin
        old_way = way_t'(w);
      end
    end
    lookup.victim_way   = inv_found ? inv_way : old_way;
    lookup.victim_valid = valid_q[lookup.index][lookup.victim_way];
    lookup.victim_dirty = dirty_q[lookup.index][lookup.victim_way];
    lookup.victim_tag   = tag_q[lookup.index][lookup.victim_way];
  end

  // An update counts as a touch of the written way
  assign touch_any = lookup.upd_en | lookup.touch_en;
  assign touch_sel = lookup.upd_en ? lookup.upd_way : lookup.touch_way;
  assign touch_age = age_q[lookup.index][touch_sel];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          valid_q[s][w] <= 1'b0;
          dirty_q[s][w] <= 1'b0;
          // Ages start as a permutation of the way numbers
          age_q[s][w]   <= age_t'(w);
        end
      end
    end else begin
      if (lookup.upd_en) begin
        valid_q[lookup.index][lookup.upd_way] <= lookup.upd_valid;
        dirty_q[lookup.index][lookup.upd_way] <= lookup.upd_dirty;
      end
      if (touch_any) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (way_t'(w) == touch_sel) begin
            age_q[lookup.index][w] <= '0;
          end else if (age_q[lookup.index][w] < touch_age) begin
            age_q[lookup.index][w] <= age_q[lookup.index][w] + 1'b1;
          end
        end
      end
    end
  end

  // Tags only change together with the state above
  always_ff @(posedge clk) begin
    if (lookup.upd_en) begin
      tag_q[lookup.index][lookup.upd_way] <= lookup.upd_tag;
    end
  end

  // A fill to a resident line must reuse its way
  a_single_match: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match));

endmodule

//--- hw/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
  input  logic                 clk,
  input  cache_pkg::index_t    rd_index,
  input  cache_pkg::way_t      rd_way,
  output cache_pkg::line_t     rd_line,
  input  logic                 wr_en,
  input  cache_pkg::index_t    wr_index,
  input  cache_pkg::way_t      wr_way,
  input  cache_pkg::byte_mask_t wr_mask,
  input  cache_pkg::line_t     wr_line
);
  import cache_pkg::*;

  // One entry per set and way, set in the upper bits
  line_t mem [NUM_LINES];

  logic [INDEX_W+WAY_W-1:0] rd_ptr;
  logic [INDEX_W+WAY_W-1:0] wr_ptr;

  assign rd_ptr = {rd_index, rd_way};
  assign wr_ptr = {wr_index, wr_way};

  // Old contents are visible until the edge
  assign rd_line = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wr_mask[b]) begin
          mem[wr_ptr][b*8 +: 8] <= wr_line[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- hw/cache_bank_ctrl.sv
`timescale 1ns/1ps

module cache_bank_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  // Address queue
  input  logic                  req_valid,
  input  logic                  req_write,
  input  cache_pkg::paddr_t     req_addr,
  input  cache_pkg::line_t      req_data,
  input  cache_pkg::byte_mask_t req_mask,
  input  cache_pkg::req_id_t    req_id,
  output logic                  aq_read,
  output logic                  cache_stall,
  output logic                  cache_miss,
  // Bus fill
  input  logic                  fill_valid,
  input  cache_pkg::paddr_t     fill_addr,
  input  cache_pkg::line_t      fill_data,
  // MSHR
  input  logic                  mshr_hit,
  input  logic                  mshr_full,
  output logic                  mshr_alloc,
  output logic                  mshr_dealloc,
  output cache_pkg::paddr_t     mshr_addr,
  output cache_pkg::req_id_t    mshr_id,
  // Serializers
  input  logic                  ser0_full,
  input  logic                  ser1_full,
  output logic                  rd_valid,
  output cache_pkg::paddr_t     rd_addr,
  output logic                  wb_valid,
  output cache_pkg::paddr_t     wb_addr,
  output cache_pkg::line_t      wb_data,
  output cache_pkg::byte_mask_t wb_mask,
  // Response
  output logic                  resp_valid,
  output logic                  resp_write,
  output cache_pkg::line_t      resp_data,
  output cache_pkg::req_id_t    resp_id,
  // Arrays
  cache_lookup_if.ctrl          lookup,
  output cache_pkg::index_t     rd_index,
  output cache_pkg::way_t       rd_way,
  input  cache_pkg::line_t      rd_line,
  output logic                  wr_en,
  output cache_pkg::index_t     wr_index,
  output cache_pkg::way_t       wr_way,
  output cache_pkg::byte_mask_t wr_mask,
  output cache_pkg::line_t      wr_line
);
  import cache_pkg::*;

  logic   fill_take;
  logic   fill_wb;
  way_t   fill_way;
  paddr_t lk_addr;
  logic   rd_miss_merge;
  logic   rd_miss_alloc;
  logic   wr_miss;
  logic   accept;
  logic   hit_acc;
  logic   miss_acc;
  paddr_t req_line;
  line_t  merged_line;

  // Fill wins the lookup port whenever port 0 can take a victim
  assign fill_take = fill_valid & ~ser0_full;
  assign lk_addr   = fill_take ? fill_addr : req_addr;

  assign lookup.index = addr_index(lk_addr);
  assign lookup.tag   = addr_tag(lk_addr);

  // A fill to a resident line rewrites it in place, no eviction
  assign fill_way = lookup.hit ? lookup.hit_way : lookup.victim_way;
  assign fill_wb  = fill_take & ~lookup.hit & lookup.victim_valid & lookup.victim_dirty;

  // Request classification, only meaningful without a fill
  assign rd_miss_merge = ~req_write & ~lookup.hit & mshr_hit;
  assign rd_miss_alloc = ~req_write & ~lookup.hit & ~mshr_hit & ~mshr_full & ~ser1_full;
  assign wr_miss       = req_write & ~lookup.hit & ~ser0_full;

  assign accept   = req_valid & ~fill_take &
                    (lookup.hit | rd_miss_merge | rd_miss_alloc | wr_miss);
  assign hit_acc  = accept & lookup.hit;
  assign miss_acc = accept & ~lookup.hit;

  assign aq_read     = accept;
  assign cache_stall = req_valid & ~accept;
  assign cache_miss  = miss_acc;

  assign req_line = line_addr(addr_tag(req_addr), addr_index(req_addr));

  assign mshr_alloc   = miss_acc & ~req_write & ~mshr_hit;
  assign mshr_dealloc = fill_take;
  assign mshr_addr    = fill_take ? fill_addr : req_line;
  assign mshr_id      = req_id;

  assign rd_valid = mshr_alloc;
  assign rd_addr  = req_line;

  // Port 0 carries either the dirty victim or a write miss
  assign wb_valid = fill_wb | (miss_acc & req_write);
  assign wb_addr  = fill_take ? line_addr(lookup.victim_tag, lookup.index) : req_line;
  assign wb_data  = fill_take ? rd_line : req_data;
  assign wb_mask  = fill_take ? '1 : req_mask;

  // Tag state, write hits mark the line dirty
  assign lookup.upd_en    = fill_take | (hit_acc & req_write);
  assign lookup.upd_way   = fill_take ? fill_way : lookup.hit_way;
  assign lookup.upd_tag   = lookup.tag;
  assign lookup.upd_valid = 1'b1;
  assign lookup.upd_dirty = ~fill_take;
  assign lookup.touch_en  = hit_acc & ~req_write;
  assign lookup.touch_way = lookup.hit_way;

  assign rd_index = lookup.index;
  assign rd_way   = fill_take ? fill_way : lookup.hit_way;

  assign wr_en    = lookup.upd_en;
  assign wr_index = lookup.index;
  assign wr_way   = lookup.upd_way;
  assign wr_mask  = fill_take ? '1 : req_mask;
  assign wr_line  = fill_take ? fill_data : req_data;

  // Line as it will read after this write
  always_comb begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (req_write && req_mask[b]) begin
        merged_line[b*8 +: 8] = req_data[b*8 +: 8];
      end else begin
        merged_line[b*8 +: 8] = rd_line[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
      resp_write <= 1'b0;
    end else begin
      resp_valid <= hit_acc;
      resp_write <= hit_acc & req_write;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_acc) begin
      resp_data <= merged_line;
      resp_id   <= req_id;
    end
  end

  // Outside blocks rely on these levels never being overrun
  a_mshr_room: assert property (@(posedge clk) disable iff (!rst_n) !(mshr_alloc && mshr_full));
  a_ser1_room: assert property (@(posedge clk) disable iff (!rst_n) !(rd_valid && ser1_full));
  a_ser0_room: assert property (@(posedge clk) disable iff (!rst_n) !(wb_valid && ser0_full));
  a_one_owner: assert property (@(posedge clk) disable iff (!rst_n) !(aq_read && fill_take));

endmodule

//--- hw/cache_bank.sv
`timescale 1ns/1ps

module cache_bank (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  logic                  req_write,
  input  cache_pkg::paddr_t     req_addr,
  input  cache_pkg::line_t      req_data,
  input  cache_pkg::byte_mask_t req_mask,
  input  cache_pkg::req_id_t    req_id,
  input  logic                  fill_valid,
  input  cache_pkg::paddr_t     fill_addr,
  input  cache_pkg::line_t      fill_data,
  input  logic                  mshr_hit,
  input  logic                  mshr_full,
  input  logic                  ser0_full,
  input  logic                  ser1_full,
  output logic                  aq_read,
  output logic                  cache_stall,
  output logic                  cache_miss,
  output logic                  mshr_alloc,
  output logic                  mshr_dealloc,
  output cache_pkg::paddr_t     mshr_addr,
  output cache_pkg::req_id_t    mshr_id,
  output logic                  rd_valid,
  output cache_pkg::paddr_t     rd_addr,
  output logic                  wb_valid,
  output cache_pkg::paddr_t     wb_addr,
  output cache_pkg::line_t      wb_data,
  output cache_pkg::byte_mask_t wb_mask,
  output logic                  resp_valid,
  output logic                  resp_write,
  output cache_pkg::line_t      resp_data,
  output cache_pkg::req_id_t    resp_id
);
  import cache_pkg::*;

  index_t     rd_index;
  way_t       rd_way;
  line_t      rd_line;
  logic       wr_en;
  index_t     wr_index;
  way_t       wr_way;
  byte_mask_t wr_mask;
  line_t      wr_line;

  cache_lookup_if lookup ();

  cache_bank_ctrl i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_mask     (req_mask),
    .req_id       (req_id),
    .aq_read      (aq_read),
    .cache_stall  (cache_stall),
    .cache_miss   (cache_miss),
    .fill_valid   (fill_valid),
    .fill_addr    (fill_addr),
    .fill_data    (fill_data),
    .mshr_hit     (mshr_hit),
    .mshr_full    (mshr_full),
    .mshr_alloc   (mshr_alloc),
    .mshr_dealloc (mshr_dealloc),
    .mshr_addr    (mshr_addr),
    .mshr_id      (mshr_id),
    .ser0_full    (ser0_full),
    .ser1_full    (ser1_full),
    .rd_valid     (rd_valid),
    .rd_addr      (rd_addr),
    .wb_valid     (wb_valid),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .wb_mask      (wb_mask),
    .resp_valid   (resp_valid),
    .resp_write   (resp_write),
    .resp_data    (resp_data),
    .resp_id      (resp_id),
    .lookup       (lookup.ctrl),
    .rd_index     (rd_index),
    .rd_way       (rd_way),
    .rd_line      (rd_line),
    .wr_en        (wr_en),
    .wr_index     (wr_index),
    .wr_way       (wr_way),
    .wr_mask      (wr_mask),
    .wr_line      (wr_line)
  );

  cache_tag_array i_tags (
    .clk    (clk),
    .rst_n  (rst_n),
    .lookup (lookup.array)
  );

  cache_data_array i_data (
    .clk      (clk),
    .rd_index (rd_index),
    .rd_way   (rd_way),
    .rd_line  (rd_line),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_way   (wr_way),
    .wr_mask  (wr_mask),
    .wr_line  (wr_line)
  );

endmodule

//--- tests/cache_ref_model.svh
// Inputs of one cycle, as the DUT sees them
typedef struct packed {
  logic       req_valid, req_write, fill_valid, mshr_hit, mshr_full, ser0_full, ser1_full;
  paddr_t     req_addr, fill_addr;
  line_t      req_data, fill_data;
  byte_mask_t req_mask;
  req_id_t    req_id;
} stim_t;

// Outputs expected in the same cycle
typedef struct packed {
  logic       aq_read, cache_stall, cache_miss, mshr_alloc, mshr_dealloc, rd_valid, wb_valid;
  logic       resp_valid, resp_write;
  paddr_t     mshr_addr, rd_addr, wb_addr;
  line_t      wb_data, resp_data;
  byte_mask_t wb_mask;
  req_id_t    mshr_id, resp_id;
} exp_t;

tag_t  ref_tag   [NUM_SETS][NUM_WAYS];
logic  ref_valid [NUM_SETS][NUM_WAYS];
logic  ref_dirty [NUM_SETS][NUM_WAYS];
age_t  ref_age   [NUM_SETS][NUM_WAYS];
line_t ref_data  [NUM_SETS][NUM_WAYS];
// Hit response due in the next cycle
exp_t  pend;

function automatic void reset_model();
  for (int s = 0; s < NUM_SETS; s++) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      ref_valid[s][w] = 1'b0;
      ref_dirty[s][w] = 1'b0;
      ref_age[s][w]   = age_t'(w);
    end
  end
  pend = '0;
endfunction

function automatic logic find_way(input index_t ix, input tag_t t, output way_t way);
  logic found;
  found = 1'b0;
  way   = '0;
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (ref_valid[ix][w] && ref_tag[ix][w] == t) begin
      found = 1'b1;
      way   = way_t'(w);
    end
  end
  return found;
endfunction

// Lowest invalid way first, else the least recently used
function automatic way_t pick_victim(input index_t ix);
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (!ref_valid[ix][w]) begin
      return way_t'(w);
    end
  end
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (ref_age[ix][w] == 2'd3) begin
      return way_t'(w);
    end
  end
  return '0;
endfunction

function automatic void touch_way(input index_t ix, input way_t way);
  age_t old;
  old = ref_age[ix][way];
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (ref_age[ix][w] < old) begin
      ref_age[ix][w] = ref_age[ix][w] + 2'd1;
    end
  end
  ref_age[ix][way] = '0;
endfunction

function automatic line_t merge_bytes(input line_t old, input line_t upd, input byte_mask_t m);
  line_t res;
  res = old;
  for (int b = 0; b < LINE_BYTES; b++) begin
    if (m[b]) begin
      res[b*8 +: 8] = upd[b*8 +: 8];
    end
  end
  return res;
endfunction

function automatic exp_t ref_step(input stim_t s);
  exp_t   e;
  index_t ix;
  tag_t   t;
  way_t   way;
  logic   hit;
  e = '0;
  e.resp_valid = pend.resp_valid;
  e.resp_write = pend.resp_write;
  e.resp_data  = pend.resp_data;
  e.resp_id    = pend.resp_id;
  pend = '0;
  if (s.fill_valid && !s.ser0_full) begin
    ix  = s.fill_addr[5:4];
    t   = s.fill_addr[14:6];
    hit = find_way(ix, t, way);
    if (!hit) begin
      way = pick_victim(ix);
    end
    e.cache_stall  = s.req_valid;
    e.mshr_dealloc = 1'b1;
    e.mshr_addr    = s.fill_addr;
    // Dirty victim goes back whole
    if (!hit && ref_valid[ix][way] && ref_dirty[ix][way]) begin
      e.wb_valid = 1'b1;
      e.wb_addr  = {ref_tag[ix][way], ix, 4'h0};
      e.wb_data  = ref_data[ix][way];
      e.wb_mask  = '1;
    end
    ref_tag[ix][way]   = t;
    ref_valid[ix][way] = 1'b1;
    ref_dirty[ix][way] = 1'b0;
    ref_data[ix][way]  = s.fill_data;
    touch_way(ix, way);
  end else if (s.req_valid) begin
    ix  = s.req_addr[5:4];
    t   = s.req_addr[14:6];
    hit = find_way(ix, t, way);
    e.aq_read = hit || (s.req_write && !s.ser0_full) ||
                (!s.req_write && (s.mshr_hit || (!s.mshr_full && !s.ser1_full)));
    e.cache_stall = !e.aq_read;
    e.cache_miss  = e.aq_read && !hit;
    if (hit) begin
      if (s.req_write) begin
        ref_data[ix][way]  = merge_bytes(ref_data[ix][way], s.req_data, s.req_mask);
        ref_dirty[ix][way] = 1'b1;
      end
      pend.resp_valid = 1'b1;
      pend.resp_write = s.req_write;
      pend.resp_data  = ref_data[ix][way];
      pend.resp_id    = s.req_id;
      touch_way(ix, way);
    end else if (e.cache_miss && s.req_write) begin
      e.wb_valid = 1'b1;
      e.wb_addr  = {t, ix, 4'h0};
      e.wb_data  = s.req_data;
      e.wb_mask  = s.req_mask;
    end else if (e.cache_miss && !s.mshr_hit) begin
      e.mshr_alloc = 1'b1;
      e.rd_valid   = 1'b1;
      e.rd_addr    = {t, ix, 4'h0};
      e.mshr_addr  = {t, ix, 4'h0};
      e.mshr_id    = s.req_id;
    end
  end
  return e;
endfunction

//--- tests/tb_cache_bank.sv
`timescale 1ns/1ps

module tb_cache_bank;
  import cache_pkg::*;

  `include "cache_ref_model.svh"

  localparam int CLK_PERIOD     = 8;
  localparam int RAND_OPS       = 2000;
  localparam int NUM_OPS        = RAND_OPS + 20;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 4 + 100;

  logic       clk;
  logic       rst_n;
  stim_t      stim;
  exp_t       expd;
  string      test_name;
  int         stall_cycles;
  logic       seen_miss;
  logic       seen_alloc;
  logic       seen_wb;
  logic       req_valid, req_write, fill_valid, mshr_hit, mshr_full, ser0_full, ser1_full;
  paddr_t     req_addr, fill_addr;
  line_t      req_data, fill_data;
  byte_mask_t req_mask;
  req_id_t    req_id;
  logic       aq_read, cache_stall, cache_miss, mshr_alloc, mshr_dealloc, rd_valid, wb_valid;
  logic       resp_valid, resp_write;
  paddr_t     mshr_addr, rd_addr, wb_addr;
  line_t      wb_data, resp_data;
  byte_mask_t wb_mask;
  req_id_t    mshr_id, resp_id;

  // Same field order as stim_t
  assign {req_valid, req_write, fill_valid, mshr_hit, mshr_full, ser0_full, ser1_full,
          req_addr, fill_addr, req_data, fill_data, req_mask, req_id} = stim;

  cache_bank i_dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Run timed out after %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "Stopping at first mismatch");
  endtask

  task automatic check_bit(input string name, input logic e, input logic a);
    if (a !== e) begin
      $display("ERROR %s %s: expected %b actual %b", test_name, name, e, a);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input paddr_t e, input paddr_t a);
    if (a !== e) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, name, e, a);
      stop_on_error();
    end
  endtask

  task automatic check_line(input string name, input line_t e, input line_t a);
    if (a !== e) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, name, e, a);
      stop_on_error();
    end
  endtask

  task automatic check_mask(input string name, input byte_mask_t e, input byte_mask_t a);
    if (a !== e) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, name, e, a);
      stop_on_error();
    end
  endtask

  task automatic check_id(input string name, input req_id_t e, input req_id_t a);
    if (a !== e) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, name, e, a);
      stop_on_error();
    end
  endtask

  // Inputs settle 1 ns after the rising edge, so the falling edge sees stable outputs
  always @(negedge clk) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      expd = ref_step(stim);
      check_bit("aq_read", expd.aq_read, aq_read);
      check_bit("cache_stall", expd.cache_stall, cache_stall);
      check_bit("cache_miss", expd.cache_miss, cache_miss);
      check_bit("mshr_alloc", expd.mshr_alloc, mshr_alloc);
      check_bit("mshr_dealloc", expd.mshr_dealloc, mshr_dealloc);
      check_bit("rd_valid", expd.rd_valid, rd_valid);
      check_bit("wb_valid", expd.wb_valid, wb_valid);
      check_bit("resp_valid", expd.resp_valid, resp_valid);
      if (expd.mshr_alloc || expd.mshr_dealloc) begin
        check_addr("mshr_addr", expd.mshr_addr, mshr_addr);
      end
      if (expd.mshr_alloc) begin
        check_id("mshr_id", expd.mshr_id, mshr_id);
      end
      if (expd.rd_valid) begin
        check_addr("rd_addr", expd.rd_addr, rd_addr);
      end
      if (expd.wb_valid) begin
        check_addr("wb_addr", expd.wb_addr, wb_addr);
        check_line("wb_data", expd.wb_data, wb_data);
        check_mask("wb_mask", expd.wb_mask, wb_mask);
      end
      if (expd.resp_valid) begin
        check_bit("resp_write", expd.resp_write, resp_write);
        check_line("resp_data", expd.resp_data, resp_data);
        check_id("resp_id", expd.resp_id, resp_id);
      end
    end
  end

  function automatic line_t rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // Few tags, so sets fill up and lines get evicted
  function automatic paddr_t rand_addr();
    paddr_t a;
    a = paddr_t'($urandom);
    a[14:6] = tag_t'($urandom_range(0, 7));
    return a;
  endfunction

  // Holds the request until aq_read, starting and ending 1 ns after an edge
  task automatic send_req(input logic wr, input paddr_t addr, input line_t data,
                          input byte_mask_t mask, input req_id_t id);
    logic took;
    took = 1'b0;
    stall_cycles = 0;
    stim.req_valid = 1'b1;
    stim.req_write = wr;
    stim.req_addr  = addr;
    stim.req_data  = data;
    stim.req_mask  = mask;
    stim.req_id    = id;
    while (!took) begin
      @(negedge clk);
      took       = aq_read;
      seen_miss  = cache_miss;
      seen_alloc = mshr_alloc;
      seen_wb    = wb_valid;
      if (!took) begin
        stall_cycles++;
      end
      @(posedge clk);
      #1;
    end
    stim.req_valid = 1'b0;
  endtask

  task automatic send_fill(input paddr_t addr, input line_t data);
    logic took;
    took = 1'b0;
    stim.fill_valid = 1'b1;
    stim.fill_addr  = addr;
    stim.fill_data  = data;
    while (!took) begin
      @(negedge clk);
      took    = mshr_dealloc;
      seen_wb = wb_valid;
      @(posedge clk);
      #1;
    end
    stim.fill_valid = 1'b0;
  endtask

  // Level 0 is mshr_full, 1 is ser1_full, 2 is ser0_full
  task automatic stall_case(input int level, input logic wr, input paddr_t addr);
    stim.mshr_full = (level == 0);
    stim.ser1_full = (level == 1);
    stim.ser0_full = (level == 2);
    fork
      send_req(wr, addr, rand_line(), 16'hffff, 7'd20);
      begin
        repeat (3) @(posedge clk);
        #1;
        stim.mshr_full = 1'b0;
        stim.ser1_full = 1'b0;
        stim.ser0_full = 1'b0;
      end
    join
    check_bit("stalled while full", 1'b1, stall_cycles == 3);
  endtask

  initial begin
    paddr_t a;
    int     done;
    logic   pending;
    void'($urandom(70));
    stim      = '0;
    rst_n     = 1'b0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "read_miss";
    a = {9'd1, 2'd1, 4'h0};
    send_req(1'b0, a | 15'h5, '0, '0, 7'd5);
    check_bit("miss allocates", 1'b1, seen_alloc);

    test_name = "read_hit";
    send_fill(a, rand_line());
    send_req(1'b0, a, '0, '0, 7'd6);
    send_req(1'b0, a | 15'h8, '0, '0, 7'd7);
    check_bit("hit is no miss", 1'b0, seen_miss);

    // Three fills take the free ways, the fourth evicts the oldest line
    test_name = "write_hit_evict";
    send_req(1'b1, a, rand_line(), 16'h00f0, 7'd8);
    for (int t = 2; t < 6; t++) begin
      send_fill({tag_t'(t), 2'd1, 4'h0}, rand_line());
    end
    check_bit("dirty victim written back", 1'b1, seen_wb);

    test_name = "write_miss";
    a = {9'd7, 2'd2, 4'h0};
    send_req(1'b1, a, rand_line(), 16'h0f0f, 7'd9);
    check_bit("write miss on port 0", 1'b1, seen_wb);
    check_bit("write miss allocates", 1'b0, seen_alloc);
    stim.mshr_hit = 1'b1;
    send_req(1'b0, a, '0, '0, 7'd10);
    check_bit("merged miss", 1'b1, seen_miss);
    check_bit("merged miss allocates", 1'b0, seen_alloc);
    stim.mshr_hit = 1'b0;

    test_name = "backpressure";
    stall_case(0, 1'b0, {9'd12, 2'd3, 4'h0});
    stall_case(1, 1'b0, {9'd13, 2'd3, 4'h0});
    stall_case(2, 1'b1, {9'd14, 2'd3, 4'h0});

    test_name = "fill_priority";
    fork
      send_req(1'b0, {9'd2, 2'd1, 4'h0}, '0, '0, 7'd11);
      send_fill({9'd15, 2'd0, 4'h0}, rand_line());
    join
    check_bit("request waits for fill", 1'b1, stall_cycles == 1);

    test_name = "random";
    pending = 1'b0;
    done    = 0;
    while (done < RAND_OPS) begin
      if (!pending && $urandom_range(0, 3) != 0) begin
        stim.req_valid = 1'b1;
        stim.req_write = $urandom_range(0, 2) == 0;
        stim.req_addr  = rand_addr();
        stim.req_data  = rand_line();
        stim.req_mask  = byte_mask_t'($urandom);
        stim.req_id    = req_id_t'($urandom);
        pending = 1'b1;
      end
      stim.mshr_hit   = $urandom_range(0, 3) == 0;
      stim.mshr_full  = $urandom_range(0, 4) == 0;
      stim.ser0_full  = $urandom_range(0, 4) == 0;
      stim.ser1_full  = $urandom_range(0, 4) == 0;
      stim.fill_valid = $urandom_range(0, 3) == 0;
      stim.fill_addr  = rand_addr();
      stim.fill_data  = rand_line();
      @(negedge clk);
      if (aq_read) begin
        pending = 1'b0;
        done++;
      end
      @(posedge clk);
      #1;
      stim.req_valid = pending;
    end

    // Let the last response reach the checker
    stim = '0;
    repeat (3) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+tests
hw/cache_pkg.sv
hw/cache_lookup_if.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/cache_bank_ctrl.sv
hw/cache_bank.sv
tests/tb_cache_bank.sv
